// ==== src/buffer_cfg_pkg.sv ====
// sizes of the banked ADC receive buffer
// CHANNELS and BUFFER_DEPTH must be powers of two, CHANNELS at least 2
package buffer_cfg_pkg;

  // one bank per ADC channel
  localparam int CHANNELS = 4;
  // samples held by a single bank
  localparam int BUFFER_DEPTH = 64;
  localparam int DATA_WIDTH = 16;

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int BANK_WIDTH = $clog2(CHANNELS);

  // highest banking mode, every channel active with one bank each
  localparam int MAX_MODE = $clog2(CHANNELS);
  localparam int MODE_WIDTH = $clog2(MAX_MODE + 1);

  // in mode 0 one channel chains all banks, so its sample count reaches
  // CHANNELS*BUFFER_DEPTH and needs a bit above bank and address
  localparam int COUNT_WIDTH = ADDR_WIDTH + BANK_WIDTH + 1;

  // bank index and address joined into one readout word index
  localparam int WORD_IDX_WIDTH = ADDR_WIDTH + BANK_WIDTH;

endpackage

// ==== src/buffer_types_pkg.sv ====
// vector types and FSM encodings of the banked ADC receive buffer
// widths follow buffer_cfg_pkg
package buffer_types_pkg;
  import buffer_cfg_pkg::*;

  typedef logic [DATA_WIDTH-1:0] sample_t;
  typedef logic [ADDR_WIDTH-1:0] bank_addr_t;
  typedef logic [BANK_WIDTH-1:0] bank_sel_t;

  // top bit set means the bank filled up
  typedef logic [ADDR_WIDTH:0] depth_t;

  // active channels = 2**mode
  typedef logic [MODE_WIDTH-1:0] mode_t;

  typedef logic [COUNT_WIDTH-1:0] count_t;
  typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;

  typedef enum logic [2:0] {
    cap_idle,
    cap_armed,
    cap_capturing,
    cap_report,
    cap_done
  } capture_state_t;

  typedef enum logic {
    rd_idle,
    rd_reading
  } readout_state_t;

endpackage

// ==== src/bank_ifs.sv ====
// bank write and bank read buses between the controllers and the banks
// rd_data follows rd_en by one cycle
interface bank_wr_if
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
();

  // one write port per bank
  logic [CHANNELS-1:0] wr_en;
  bank_addr_t [CHANNELS-1:0] wr_addr;
  sample_t [CHANNELS-1:0] wr_data;

  modport master (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport slave (
    input wr_en,
    input wr_addr,
    input wr_data
  );

endinterface

interface bank_rd_if
  import buffer_types_pkg::*;
();

  // single read port shared by all banks
  logic rd_en;
  bank_sel_t rd_bank;
  bank_addr_t rd_addr;
  sample_t rd_data;

  modport master (
    output rd_en,
    output rd_bank,
    output rd_addr,
    input rd_data
  );

  modport slave (
    input rd_en,
    input rd_bank,
    input rd_addr,
    output rd_data
  );

endinterface

// ==== src/capture_ctrl.sv ====
// capture control with arm/start/stop, channel to bank routing and write depth report
// in mode m only channels below 2**m are stored; mode is taken in idle only
// a sample presented on the edge that samples stop is not stored
module capture_ctrl
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic                   adc_clk_i,
  input  logic                   rst_n_i,
  input  sample_t [CHANNELS-1:0] adc_data_i,
  input  logic [CHANNELS-1:0]    adc_valid_i,
  input  logic [2:0]             arm_start_stop_i,
  input  logic                   arm_start_stop_valid_i,
  input  mode_t                  banking_mode_i,
  input  logic                   banking_mode_valid_i,
  input  logic                   capture_sw_reset_i,
  output depth_t [CHANNELS-1:0]  write_depth_o,
  output logic                   write_depth_valid_o,
  input  logic                   write_depth_ready_i,
  output logic                   capture_done_o,
  bank_wr_if.master              wr
);

  capture_state_t state_q;
  mode_t mode_q;
  count_t count_q [CHANNELS];
  depth_t [CHANNELS-1:0] depth_q;
  logic depth_valid_q;

  logic arm;
  logic start;
  logic stop;
  logic fill;
  logic [CHANNELS-1:0] store;
  count_t full_count;
  bank_sel_t chan_mask;
  depth_t [CHANNELS-1:0] depth_calc;

  assign arm = arm_start_stop_valid_i && (arm_start_stop_i == 3'd4);
  assign start = arm_start_stop_valid_i && (arm_start_stop_i == 3'd2)
                 && (state_q == cap_armed);
  assign stop = arm_start_stop_valid_i && (arm_start_stop_i == 3'd1);

  // each channel owns CHANNELS >> mode banks
  assign full_count = count_t'(CHANNELS * BUFFER_DEPTH) >> mode_q;
  assign chan_mask = bank_sel_t'((1 << mode_q) - 1);

  always_comb begin
    fill = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      store[c] = (state_q == cap_capturing) && !stop && !capture_sw_reset_i
                 && adc_valid_i[c] && (c <= int'(chan_mask));
      if (store[c] && (count_q[c] == full_count - 1'b1)) begin
        fill = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bank b belongs to channel b mod 2**m and takes block b >> m of its count
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    bank_sel_t ch;
    count_t cnt;
    count_t used;
    count_t blk;
    for (int b = 0; b < CHANNELS; b++) begin
      ch = bank_sel_t'(b) & chan_mask;
      cnt = count_q[ch];
      // banks this channel has already filled
      used = cnt >> ADDR_WIDTH;
      blk = count_t'(b >> mode_q);
      wr.wr_en[b] = store[ch] && (used == blk);
      wr.wr_addr[b] = cnt[ADDR_WIDTH-1:0];
      wr.wr_data[b] = adc_data_i[ch];
      if (used > blk) begin
        depth_calc[b] = depth_t'(BUFFER_DEPTH);
      end else if (used == blk) begin
        depth_calc[b] = depth_t'(cnt[ADDR_WIDTH-1:0]);
      end else begin
        depth_calc[b] = '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // capture FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk_i) begin
    if (!rst_n_i || capture_sw_reset_i) begin
      state_q <= cap_idle;
      depth_valid_q <= 1'b0;
    end else begin
      case (state_q)
        cap_idle: begin
          if (arm) begin
            state_q <= cap_armed;
          end
        end
        cap_armed: begin
          if (start) begin
            state_q <= cap_capturing;
          end
        end
        cap_capturing: begin
          if (stop || fill) begin
            state_q <= cap_report;
          end
        end
        cap_report: begin
          // counters are final here, valid rises one cycle after entry
          if (!depth_valid_q) begin
            depth_valid_q <= 1'b1;
          end else if (write_depth_ready_i) begin
            depth_valid_q <= 1'b0;
            state_q <= cap_done;
          end
        end
        cap_done: begin
          if (arm) begin
            state_q <= cap_armed;
          end
        end
        default: state_q <= cap_idle;
      endcase
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (!rst_n_i) begin
      mode_q <= '0;
    end else if (banking_mode_valid_i && (state_q == cap_idle)) begin
      // modes above MAX_MODE would ask for more channels than exist
      mode_q <= (banking_mode_i > mode_t'(MAX_MODE)) ? mode_t'(MAX_MODE) : banking_mode_i;
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (!rst_n_i || start) begin
      for (int c = 0; c < CHANNELS; c++) begin
        count_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (store[c]) begin
          count_q[c] <= count_q[c] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if ((state_q == cap_report) && !depth_valid_q) begin
      depth_q <= depth_calc;
    end
  end

  assign write_depth_o = depth_q;
  assign write_depth_valid_o = depth_valid_q;
  assign capture_done_o = (state_q == cap_done);

endmodule

// ==== src/sample_banks.sv ====
// CHANNELS sample memories, one write port each, one shared read port
// read data appears one cycle after rd_en and holds until the next read
module sample_banks
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic      adc_clk_i,
  bank_wr_if.slave  wr,
  bank_rd_if.slave  rd
);

  sample_t bank_word_q [CHANNELS];
  bank_sel_t rd_bank_q;

  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    sample_t mem [BUFFER_DEPTH];

    always_ff @(posedge adc_clk_i) begin
      if (wr.wr_en[b]) begin
        mem[wr.wr_addr[b]] <= wr.wr_data[b];
      end
    end

    // registered read, only the selected bank is enabled
    always_ff @(posedge adc_clk_i) begin
      if (rd.rd_en && (rd.rd_bank == bank_sel_t'(b))) begin
        bank_word_q[b] <= mem[rd.rd_addr];
      end
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (rd.rd_en) begin
      rd_bank_q <= rd.rd_bank;
    end
  end

  assign rd.rd_data = bank_word_q[rd_bank_q];

endmodule

// ==== src/readout_ctrl.sv ====
// readout of all banks, bank 0 first, ascending address within a bank
// start is only accepted once capture is done and readout is idle
// reads are issued only when the two-entry output buffer has room
module readout_ctrl
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic      adc_clk_i,
  input  logic      rst_n_i,
  input  logic      capture_done_i,
  input  logic      readout_sw_reset_i,
  input  logic      readout_start_valid_i,
  output logic      readout_start_ready_o,
  output sample_t   readout_data_o,
  output logic      readout_valid_o,
  input  logic      readout_ready_i,
  output logic      readout_last_o,
  bank_rd_if.master rd
);

  readout_state_t state_q;
  word_idx_t idx_q;
  logic issued_all_q;
  logic inflight_q;
  logic inflight_last_q;

  // two-entry output buffer
  sample_t buf_data_q [2];
  logic [1:0] buf_last_q;
  logic [1:0] buf_count_q;
  logic wr_ptr_q;
  logic rd_ptr_q;

  logic start;
  logic pop;
  logic issue;

  assign readout_start_ready_o = capture_done_i && (state_q == rd_idle);
  assign start = readout_start_valid_i && readout_start_ready_o;

  assign readout_valid_o = (buf_count_q != 2'd0);
  assign readout_data_o = buf_data_q[rd_ptr_q];
  assign readout_last_o = readout_valid_o && buf_last_q[rd_ptr_q];
  assign pop = readout_valid_o && readout_ready_i;

  // room counts the word in flight and the pop of this cycle
  assign issue = (state_q == rd_reading) && !issued_all_q
                 && ((buf_count_q + 2'(inflight_q) - 2'(pop)) < 2'd2);

  assign rd.rd_en = issue;
  assign rd.rd_bank = idx_q[WORD_IDX_WIDTH-1:ADDR_WIDTH];
  assign rd.rd_addr = idx_q[ADDR_WIDTH-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // sequencing and buffer pointers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk_i) begin
    if (!rst_n_i || readout_sw_reset_i) begin
      state_q <= rd_idle;
      idx_q <= '0;
      issued_all_q <= 1'b0;
      inflight_q <= 1'b0;
      inflight_last_q <= 1'b0;
      buf_count_q <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (start) begin
        state_q <= rd_reading;
        idx_q <= '0;
        issued_all_q <= 1'b0;
      end else if (pop && readout_last_o) begin
        state_q <= rd_idle;
      end
      if (issue) begin
        idx_q <= idx_q + 1'b1;
        issued_all_q <= &idx_q;
      end
      inflight_q <= issue;
      inflight_last_q <= issue && (&idx_q);
      if (inflight_q) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      buf_count_q <= buf_count_q + 2'(inflight_q) - 2'(pop);
    end
  end

  // the word read last cycle lands in the buffer with its last flag
  always_ff @(posedge adc_clk_i) begin
    if (inflight_q) begin
      buf_data_q[wr_ptr_q] <= rd.rd_data;
      buf_last_q[wr_ptr_q] <= inflight_last_q;
    end
  end

endmodule

// ==== src/adc_buffer.sv ====
// banked ADC receive buffer, single clock domain on adc_clk_i
// write_depth_o packs one depth per bank, bank 0 in the low bits
module adc_buffer
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic                   adc_clk_i,
  input  logic                   rst_n_i,
  input  sample_t [CHANNELS-1:0] adc_data_i,
  input  logic [CHANNELS-1:0]    adc_valid_i,
  input  logic [2:0]             arm_start_stop_i,
  input  logic                   arm_start_stop_valid_i,
  input  mode_t                  banking_mode_i,
  input  logic                   banking_mode_valid_i,
  input  logic                   capture_sw_reset_i,
  input  logic                   readout_sw_reset_i,
  input  logic                   readout_start_valid_i,
  output logic                   readout_start_ready_o,
  output depth_t [CHANNELS-1:0]  write_depth_o,
  output logic                   write_depth_valid_o,
  input  logic                   write_depth_ready_i,
  output sample_t                readout_data_o,
  output logic                   readout_valid_o,
  input  logic                   readout_ready_i,
  output logic                   readout_last_o
);

  bank_wr_if wr_bus ();
  bank_rd_if rd_bus ();

  logic capture_done;

  capture_ctrl capture_i (
    .adc_clk_i              (adc_clk_i),
    .rst_n_i                (rst_n_i),
    .adc_data_i             (adc_data_i),
    .adc_valid_i            (adc_valid_i),
    .arm_start_stop_i       (arm_start_stop_i),
    .arm_start_stop_valid_i (arm_start_stop_valid_i),
    .banking_mode_i         (banking_mode_i),
    .banking_mode_valid_i   (banking_mode_valid_i),
    .capture_sw_reset_i     (capture_sw_reset_i),
    .write_depth_o          (write_depth_o),
    .write_depth_valid_o    (write_depth_valid_o),
    .write_depth_ready_i    (write_depth_ready_i),
    .capture_done_o         (capture_done),
    .wr                     (wr_bus.master)
  );

  sample_banks banks_i (
    .adc_clk_i (adc_clk_i),
    .wr        (wr_bus.slave),
    .rd        (rd_bus.slave)
  );

  readout_ctrl readout_i (
    .adc_clk_i             (adc_clk_i),
    .rst_n_i               (rst_n_i),
    .capture_done_i        (capture_done),
    .readout_sw_reset_i    (readout_sw_reset_i),
    .readout_start_valid_i (readout_start_valid_i),
    .readout_start_ready_o (readout_start_ready_o),
    .readout_data_o        (readout_data_o),
    .readout_valid_o       (readout_valid_o),
    .readout_ready_i       (readout_ready_i),
    .readout_last_o        (readout_last_o),
    .rd                    (rd_bus.master)
  );

endmodule

// ==== verif/adc_buffer_tb.sv ====
// testbench for the banked ADC receive buffer
// runs modes 0, 2 and 1 and checks depths, readout order, flow control and sw resets
// later tests rely on the memory model filled by the mode 0 capture
module adc_buffer_tb
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
();

  localparam int WORDS = CHANNELS * BUFFER_DEPTH;
  // rough cycle counts per test with capture at 3/4 valid rate plus readout
  localparam int LEN_RESET = 10;
  localparam int LEN_T1 = 16;
  localparam int LEN_T2 = 2 * WORDS + 64;
  localparam int LEN_T3 = WORDS + 128;
  localparam int LEN_T4 = 2 * WORDS + 64;
  localparam int LEN_T5 = 3 * WORDS + 256;
  localparam int WATCHDOG_CYCLES =
    5 * (LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5);

  logic adc_clk_i;
  logic rst_n_i;
  sample_t [CHANNELS-1:0] adc_data_i;
  logic [CHANNELS-1:0] adc_valid_i;
  logic [2:0] arm_start_stop_i;
  logic arm_start_stop_valid_i;
  mode_t banking_mode_i;
  logic banking_mode_valid_i;
  logic capture_sw_reset_i;
  logic readout_sw_reset_i;
  logic readout_start_valid_i;
  logic readout_start_ready_o;
  depth_t [CHANNELS-1:0] write_depth_o;
  logic write_depth_valid_o;
  logic write_depth_ready_i;
  sample_t readout_data_o;
  logic readout_valid_o;
  logic readout_ready_i;
  logic readout_last_o;

  int seed = 32'h4c08_2ea0;
  int errors = 0;
  int test_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int depth_xfers = 0;
  int stop_cycles;

  // words expected in each bank, and samples stored per channel this capture
  sample_t mem_model [CHANNELS][BUFFER_DEPTH];
  int sample_count [CHANNELS];

  adc_buffer DUT (.*);

  initial adc_clk_i = 1'b0;
  always #2 adc_clk_i = ~adc_clk_i;

  always @(posedge adc_clk_i) begin
    if (write_depth_valid_o && write_depth_ready_i) begin
      depth_xfers++;
    end
  end

  readout_hold: assert property (@(posedge adc_clk_i) disable iff (!rst_n_i)
    readout_valid_o && !readout_ready_i && !readout_sw_reset_i
    |=> readout_valid_o && $stable(readout_data_o))
  else begin
    $display("readout valid or data changed while ready was low");
    errors++;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk_i);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic note_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %0d %s: passed", tests_passed + tests_failed, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_passed + tests_failed, name);
    end
    test_errors = errors;
  endtask

  task automatic drive_samples();
    logic [31:0] r;
    for (int c = 0; c < CHANNELS; c++) begin
      r = $random(seed);
      adc_data_i[c] <= r[DATA_WIDTH-1:0];
      // valid about three cycles in four
      adc_valid_i[c] <= (r[31:30] != 2'b00);
    end
  endtask

  // log what the DUT samples on this edge, routed as the banking rule says
  task automatic record_samples(input int mode, inout bit filled);
    int full;
    int bank;
    full = WORDS >> mode;
    for (int c = 0; c < (1 << mode); c++) begin
      if (adc_valid_i[c] && sample_count[c] < full) begin
        bank = c + (sample_count[c] / BUFFER_DEPTH) * (1 << mode);
        mem_model[bank][sample_count[c] % BUFFER_DEPTH] = adc_data_i[c];
        sample_count[c]++;
        if (sample_count[c] == full) begin
          filled = 1'b1;
        end
      end
    end
  endtask

  function automatic depth_t expected_depth(input int bank, input int mode);
    int rem;
    rem = sample_count[bank % (1 << mode)] - (bank >> mode) * BUFFER_DEPTH;
    if (rem >= BUFFER_DEPTH) begin
      return depth_t'(1) << ADDR_WIDTH;
    end else if (rem > 0) begin
      return depth_t'(rem);
    end
    return '0;
  endfunction

  task automatic send_cmd(input logic [2:0] cmd);
    @(posedge adc_clk_i);
    arm_start_stop_i <= cmd;
    arm_start_stop_valid_i <= 1'b1;
    @(posedge adc_clk_i);
    arm_start_stop_valid_i <= 1'b0;
  endtask

  task automatic capture_reset_pulse();
    @(posedge adc_clk_i);
    capture_sw_reset_i <= 1'b1;
    @(posedge adc_clk_i);
    capture_sw_reset_i <= 1'b0;
  endtask

  // stop_cycles of 0 runs until a channel fills its buffer
  task automatic run_capture(input int mode, input int stop_cycles);
    int cyc;
    bit filled;
    cyc = 0;
    filled = 1'b0;
    capture_reset_pulse();
    @(posedge adc_clk_i);
    banking_mode_i <= mode_t'(mode);
    banking_mode_valid_i <= 1'b1;
    @(posedge adc_clk_i);
    banking_mode_valid_i <= 1'b0;
    send_cmd(3'd4);
    // samples presented while armed and with start are not stored
    drive_samples();
    send_cmd(3'd2);
    for (int c = 0; c < CHANNELS; c++) begin
      sample_count[c] = 0;
    end
    // first stored sample is the one presented on the edge after start
    drive_samples();
    while (!filled && (stop_cycles == 0 || cyc < stop_cycles)) begin
      @(posedge adc_clk_i);
      record_samples(mode, filled);
      cyc++;
      if (!filled) begin
        drive_samples();
      end
    end
    if (!filled) begin
      // the samples presented together with stop are dropped
      arm_start_stop_i <= 3'd1;
      arm_start_stop_valid_i <= 1'b1;
      @(posedge adc_clk_i);
      arm_start_stop_valid_i <= 1'b0;
    end
    adc_valid_i <= '0;
  endtask

  task automatic check_depth(input int mode);
    depth_t exp;
    depth_xfers = 0;
    do @(posedge adc_clk_i); while (!write_depth_valid_o);
    for (int b = 0; b < CHANNELS; b++) begin
      exp = expected_depth(b, mode);
      assert (write_depth_o[b] == exp) else begin
        $display("Mismatch write_depth_o[%0d]: got 0x%0h, expected 0x%0h",
                 b, write_depth_o[b], exp);
        errors++;
      end
    end
    write_depth_ready_i <= 1'b1;
    @(posedge adc_clk_i);
    write_depth_ready_i <= 1'b0;
    repeat (2) @(posedge adc_clk_i);
    assert (depth_xfers == 1 && !write_depth_valid_o) else
      note_failure($sformatf("write depth transferred %0d times, expected once", depth_xfers));
    assert (readout_start_ready_o) else
      note_failure("readout start not ready after the write depth transfer");
  endtask

  task automatic check_word(input int k);
    sample_t exp;
    exp = mem_model[k / BUFFER_DEPTH][k % BUFFER_DEPTH];
    assert (readout_data_o == exp) else begin
      $display("Mismatch readout_data_o word %0d: got 0x%0h, expected 0x%0h",
               k, readout_data_o, exp);
      errors++;
    end
    assert (readout_last_o == (k == WORDS - 1)) else begin
      $display("Mismatch readout_last_o word %0d: got 0x%0h, expected 0x%0h",
               k, readout_last_o, (k == WORDS - 1));
      errors++;
    end
  endtask

  // reads stop_at words from bank 0, address 0 on
  task automatic read_out(input bit random_ready, input int stop_at);
    int k;
    int edges;
    int first_edge;
    logic [31:0] r;
    k = 0;
    edges = 0;
    first_edge = 0;
    @(posedge adc_clk_i);
    readout_start_valid_i <= 1'b1;
    @(posedge adc_clk_i);
    assert (readout_start_ready_o) else note_failure("readout start refused after capture");
    readout_start_valid_i <= 1'b0;
    r = $random(seed);
    readout_ready_i <= random_ready ? r[0] : 1'b1;
    while (k < stop_at) begin
      @(posedge adc_clk_i);
      edges++;
      if (readout_valid_o && first_edge == 0) begin
        first_edge = edges;
      end
      if (readout_valid_o && readout_ready_i) begin
        check_word(k);
        k++;
      end
      r = $random(seed);
      readout_ready_i <= random_ready ? r[0] : 1'b1;
    end
    readout_ready_i <= 1'b0;
    // valid rises in the second cycle after the accepting edge
    assert (first_edge == 3) else
      note_failure("first readout word did not arrive two cycles after start");
    if (stop_at == WORDS) begin
      @(posedge adc_clk_i);
      assert (!readout_valid_o) else note_failure("readout still valid after the last word");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n_i = 1'b0;
    adc_data_i = '0;
    adc_valid_i = '0;
    arm_start_stop_i = '0;
    arm_start_stop_valid_i = 1'b0;
    banking_mode_i = '0;
    banking_mode_valid_i = 1'b0;
    capture_sw_reset_i = 1'b0;
    readout_sw_reset_i = 1'b0;
    readout_start_valid_i = 1'b0;
    write_depth_ready_i = 1'b0;
    readout_ready_i = 1'b0;
    repeat (LEN_RESET) @(posedge adc_clk_i);
    rst_n_i <= 1'b1;

    @(posedge adc_clk_i);
    assert (!write_depth_valid_o && !readout_valid_o && !readout_start_ready_o) else
      note_failure("outputs not idle after reset");
    readout_start_valid_i <= 1'b1;
    @(posedge adc_clk_i);
    assert (!readout_start_ready_o) else note_failure("readout start accepted after reset");
    readout_start_valid_i <= 1'b0;
    repeat (8) begin
      @(posedge adc_clk_i);
      assert (!readout_valid_o) else note_failure("readout ran without a finished capture");
    end
    end_test("reset state and refused readout start");

    run_capture(0, 0);
    check_depth(0);
    read_out(1'b0, WORDS);
    end_test("mode 0 capture until full");

    stop_cycles = 20 + ($random(seed) & 31);
    run_capture(2, stop_cycles);
    check_depth(2);
    read_out(1'b0, WORDS);
    end_test("mode 2 capture with stop");

    read_out(1'b1, WORDS);
    end_test("readout under random ready");

    // mode 1 with a readout reset mid-stream, then a capture reset
    stop_cycles = 30 + ($random(seed) & 63);
    run_capture(1, stop_cycles);
    check_depth(1);
    read_out(1'b0, 40);
    @(posedge adc_clk_i);
    readout_sw_reset_i <= 1'b1;
    @(posedge adc_clk_i);
    readout_sw_reset_i <= 1'b0;
    @(posedge adc_clk_i);
    assert (!readout_valid_o) else note_failure("readout valid still high after readout reset");
    read_out(1'b0, WORDS);
    capture_reset_pulse();
    @(posedge adc_clk_i);
    assert (!readout_start_ready_o && !write_depth_valid_o) else
      note_failure("capture reset left readout start ready");
    stop_cycles = 30 + ($random(seed) & 63);
    run_capture(1, stop_cycles);
    check_depth(1);
    read_out(1'b0, WORDS);
    end_test("mode 1 with software resets");

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/buffer_cfg_pkg.sv
src/buffer_types_pkg.sv
src/bank_ifs.sv
src/capture_ctrl.sv
src/sample_banks.sv
src/readout_ctrl.sv
src/adc_buffer.sv
verif/adc_buffer_tb.sv

// ==== Makefile ====
# Verilator simulation of the banked ADC receive buffer
TOP = adc_buffer_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
